//--- hw/block_walker.sv
`timescale 1ns/1ps
`default_nettype none

`include "ub_config.svh"

module block_walker import ub_geom_pkg::*, ub_data_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  img_cfg_t   cfg,
    input  logic       cfg_valid,
    output logic       cfg_ready,
    output img_cfg_t   cur_cfg,
    output fetch_req_t fetch_req,
    output logic       fetch_valid,
    input  logic       fetch_ready,
    input  logic       fill_done,
    input  window_t    window,
    output block_t     blk,
    output logic       blk_valid,
    input  logic       blk_ready
);

    walk_state_t state;
    coord_t      org_row;
    coord_t      org_col;
    group_t      grp;
    logic [3:0]  grp_cnt;
    group_t      last_grp;
    coord_t      last_row_org;
    coord_t      last_col_org;
    logic        is_last_grp;
    logic        is_last_col;
    logic        is_last_row;
    logic        is_last_blk;
    logic        cfg_xfer;
    logic        blk_xfer;

    function automatic coord_t neg_pad(input pad_t pad);
        return -coord_t'(pad);
    endfunction

    // Origin of the last window along one axis of the padded image
    function automatic coord_t last_origin(input dim_t size, input pad_t pad_a, input pad_t pad_b);
        coord_t padded;
        coord_t span;
        padded = coord_t'(size) + coord_t'(pad_a) + coord_t'(pad_b);
        span = padded - coord_t'(`UB_WIN - `UB_STRIDE + 1);   // Rounds the step count up
        return coord_t'((span / `UB_STRIDE) * `UB_STRIDE) + neg_pad(pad_a);
    endfunction

    assign cfg_ready = (state == IDLE);
    assign blk_valid = (state == PRESENT);
    assign cfg_xfer  = cfg_valid && cfg_ready;
    assign blk_xfer  = blk_valid && blk_ready;

    always_ff @(posedge clk) begin
        if (cfg_xfer) cur_cfg <= cfg;
    end

    assign grp_cnt  = 4'((6'(cur_cfg.num_channels) + 6'(`UB_LANES - 1)) / `UB_LANES);
    assign last_grp = group_t'(grp_cnt - 4'd1);

    assign last_row_org = last_origin(cur_cfg.height, cur_cfg.pad_top, cur_cfg.pad_bottom);
    assign last_col_org = last_origin(cur_cfg.width, cur_cfg.pad_left, cur_cfg.pad_right);

    assign is_last_grp = (grp == last_grp);
    assign is_last_col = (org_col == last_col_org);
    assign is_last_row = (org_row == last_row_org);
    assign is_last_blk = is_last_grp && is_last_col && is_last_row;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            fetch_valid <= 1'b0;
            grp         <= '0;
            org_row     <= '0;
            org_col     <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (cfg_xfer) begin
                        org_row     <= neg_pad(cfg.pad_top);
                        org_col     <= neg_pad(cfg.pad_left);
                        grp         <= '0;
                        fetch_valid <= 1'b1;
                        state       <= FETCH;
                    end
                end
                FETCH: begin
                    if (fetch_valid && fetch_ready) fetch_valid <= 1'b0;
                    if (fill_done) state <= PRESENT;
                end
                PRESENT: begin
                    if (blk_xfer) begin
                        if (is_last_blk) begin
                            state <= IDLE;
                        end else begin
                            fetch_valid <= 1'b1;
                            state       <= FETCH;
                        end
                        if (!is_last_grp) begin
                            grp <= grp + 1'b1;   // Same spot, next 4 channels
                        end else begin
                            grp <= '0;
                            if (!is_last_col) begin
                                org_col <= org_col + coord_t'(`UB_STRIDE);
                            end else begin
                                org_col <= neg_pad(cur_cfg.pad_left);   // Wrap to next row
                                org_row <= org_row + coord_t'(`UB_STRIDE);
                            end
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign fetch_req = '{origin_row: org_row, origin_col: org_col, group: grp};

    assign blk = '{window: window, origin_row: org_row, origin_col: org_col, group: grp,
                   last_group: is_last_grp, last_block: is_last_blk};

    // Store must not refill the window while a block waits
    a_blk_hold: assert property (@(posedge clk) disable iff (reset)
        blk_valid && !blk_ready |=> blk_valid && $stable(blk));

    a_fetch_state: assert property (@(posedge clk) disable iff (reset)
        fetch_valid |-> state == FETCH);

endmodule

`default_nettype wire

//--- hw/ub_config.svh
`ifndef UB_CONFIG_SVH
`define UB_CONFIG_SVH

// Image size limits, in pixels
`define UB_MAX_IMG_W 16
`define UB_MAX_IMG_H 16

// Window geometry
`define UB_WIN 7      // Window side
`define UB_STRIDE 4   // Step between window origins

// Largest padding on any side
`define UB_MAX_PAD 3

// Channel groups packed in one RAM word, 4 channels each
`define UB_LANES 4

// One pixel word carries one channel group
`define UB_PIXEL_W 32

`define UB_RAM_ADDR_W 8

`endif

//--- hw/ub_data_pkg.sv
`default_nettype none

`include "ub_config.svh"

package ub_data_pkg;

    import ub_geom_pkg::*;

    typedef logic [`UB_PIXEL_W-1:0] pixel_t;
    typedef logic [`UB_RAM_ADDR_W-1:0] ram_addr_t;

    // Lane 3 carries group 0, lane 0 carries group 3
    typedef pixel_t [`UB_LANES-1:0] ram_word_t;

    typedef struct packed {
        logic      re;
        ram_addr_t addr;
    } ram_req_t;

    // One window position on its way into the store
    typedef struct packed {
        logic     valid;
        logic     pad;     // Outside the image, write zero
        win_idx_t row;
        win_idx_t col;
        group_t   group;
    } store_wr_t;

    typedef pixel_t [`UB_WIN-1:0][`UB_WIN-1:0] window_t;   // [row][col]

    typedef struct packed {
        window_t window;
        coord_t  origin_row;
        coord_t  origin_col;
        group_t  group;
        logic    last_group;   // Final group of this spatial block
        logic    last_block;   // Final block of the image
    } block_t;

endpackage

`default_nettype wire

//--- hw/ub_geom_pkg.sv
`default_nettype none

`include "ub_config.svh"

package ub_geom_pkg;

    typedef logic [$clog2(`UB_MAX_IMG_W + 1)-1:0] dim_t;   // Width or height
    typedef logic [$clog2(`UB_MAX_PAD + 1)-1:0] pad_t;

    typedef struct packed {
        dim_t                                        width;
        dim_t                                        height;
        logic [$clog2(`UB_LANES * `UB_LANES + 1)-1:0] num_channels;
        pad_t                                        pad_top;
        pad_t                                        pad_bottom;
        pad_t                                        pad_left;
        pad_t                                        pad_right;
    } img_cfg_t;

    // Image coordinate, negative inside top and left padding
    typedef logic signed [$clog2(`UB_MAX_IMG_W + 2 * `UB_MAX_PAD):0] coord_t;

    typedef logic [$clog2(`UB_WIN)-1:0] win_idx_t;     // Position inside the window
    typedef logic [$clog2(`UB_LANES)-1:0] group_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,     // Window being filled
        PRESENT    // Block offered on the output
    } walk_state_t;

    typedef struct packed {
        coord_t origin_row;
        coord_t origin_col;
        group_t group;
    } fetch_req_t;

endpackage

`default_nettype wire

//--- hw/unified_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module unified_buffer import ub_geom_pkg::*, ub_data_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  img_cfg_t  cfg,
    input  logic      cfg_valid,
    output logic      cfg_ready,
    output ram_req_t  ram_req,
    input  ram_word_t ram_dout,
    output block_t    blk,
    output logic      blk_valid,
    input  logic      blk_ready
);

    img_cfg_t   cur_cfg;       // Held by the walker for the whole image
    fetch_req_t fetch_req;
    logic       fetch_valid;
    logic       fetch_ready;
    store_wr_t  store_wr;
    logic       fill_done;
    window_t    window;

    block_walker u_walker (
        .clk         (clk),
        .reset       (reset),
        .cfg         (cfg),
        .cfg_valid   (cfg_valid),
        .cfg_ready   (cfg_ready),
        .cur_cfg     (cur_cfg),
        .fetch_req   (fetch_req),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fill_done   (fill_done),
        .window      (window),
        .blk         (blk),
        .blk_valid   (blk_valid),
        .blk_ready   (blk_ready)
    );

    window_fetcher u_fetcher (
        .clk         (clk),
        .reset       (reset),
        .cur_cfg     (cur_cfg),
        .fetch_req   (fetch_req),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .ram_req     (ram_req),
        .store_wr    (store_wr)
    );

    window_store u_store (
        .clk       (clk),
        .reset     (reset),
        .ram_dout  (ram_dout),
        .store_wr  (store_wr),
        .fill_done (fill_done),
        .window    (window)
    );

endmodule

`default_nettype wire

//--- hw/window_fetcher.sv
`timescale 1ns/1ps
`default_nettype none

`include "ub_config.svh"

module window_fetcher import ub_geom_pkg::*, ub_data_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  img_cfg_t   cur_cfg,
    input  fetch_req_t fetch_req,
    input  logic       fetch_valid,
    output logic       fetch_ready,
    output ram_req_t   ram_req,
    output store_wr_t  store_wr
);

    localparam win_idx_t LAST_IDX = win_idx_t'(`UB_WIN - 1);

    logic       busy;
    fetch_req_t req_q;
    win_idx_t   row;
    win_idx_t   col;
    coord_t     abs_row;
    coord_t     abs_col;
    logic       pad;
    ram_addr_t  addr;

    assign fetch_ready = !busy;

    always_ff @(posedge clk) begin
        if (fetch_valid && fetch_ready) req_q <= fetch_req;
    end

    // Row-major walk over the 49 positions, one per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            row  <= '0;
            col  <= '0;
        end else if (!busy) begin
            if (fetch_valid) begin
                busy <= 1'b1;
                row  <= '0;
                col  <= '0;
            end
        end else if (col == LAST_IDX) begin
            col <= '0;
            if (row == LAST_IDX) begin
                busy <= 1'b0;
            end else begin
                row <= row + 1'b1;
            end
        end else begin
            col <= col + 1'b1;
        end
    end

    assign abs_row = req_q.origin_row + coord_t'(row);
    assign abs_col = req_q.origin_col + coord_t'(col);

    // Anything outside the image is padding
    assign pad = (abs_row < 0) || (abs_row >= coord_t'(cur_cfg.height)) ||
                 (abs_col < 0) || (abs_col >= coord_t'(cur_cfg.width));

    assign addr = ram_addr_t'(abs_row) * ram_addr_t'(cur_cfg.width) + ram_addr_t'(abs_col);

    assign ram_req = '{re: busy && !pad, addr: addr};

    assign store_wr = '{valid: busy, pad: pad, row: row, col: col, group: req_q.group};

    // Padding never reaches the RAM, so reads stay inside the image area
    a_read_in_image: assert property (@(posedge clk) disable iff (reset)
        ram_req.re |-> 10'(ram_req.addr) < 10'(cur_cfg.width) * 10'(cur_cfg.height));

endmodule

`default_nettype wire

//--- hw/window_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "ub_config.svh"

module window_store import ub_geom_pkg::*, ub_data_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  ram_word_t ram_dout,
    input  store_wr_t store_wr,
    output logic      fill_done,
    output window_t   window
);

    localparam win_idx_t LAST_IDX = win_idx_t'(`UB_WIN - 1);

    store_wr_t wr_q;    // Entry lined up with ram_dout
    pixel_t    lane;
    pixel_t    rev;
    pixel_t    pix;
    window_t   win_q;

    always_ff @(posedge clk) begin
        wr_q <= store_wr;
        if (reset) wr_q.valid <= 1'b0;
    end

    // Group 0 sits in the top lane
    assign lane = ram_dout[group_t'(`UB_LANES - 1) - wr_q.group];

    // RAM words are little-endian per lane
    assign rev = {<<8{lane}};
    assign pix = wr_q.pad ? '0 : rev;

    always_ff @(posedge clk) begin
        if (wr_q.valid) begin
            win_q[wr_q.row][wr_q.col] <= pix;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fill_done <= 1'b0;
        end else begin
            fill_done <= wr_q.valid && (wr_q.row == LAST_IDX) && (wr_q.col == LAST_IDX);
        end
    end

    assign window = win_q;

    // An image position needs a read one cycle earlier, so RAM data must be known here
    a_read_data: assert property (@(posedge clk) disable iff (reset)
        wr_q.valid && !wr_q.pad |-> !$isunknown(lane));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_unified_buffer \
    -f tb.f \
    -o sim_tb

# The run may stop through $fatal, so its status is not trusted here
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "Result: FAIL"
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    echo "Result: FAIL, the run ended without a verdict"
    exit 1
fi
echo "Result: PASS"

//--- tb.f
+incdir+hw
hw/ub_geom_pkg.sv
hw/ub_data_pkg.sv
hw/block_walker.sv
hw/window_fetcher.sv
hw/window_store.sv
hw/unified_buffer.sv
tb/tb_unified_buffer.sv

//--- tb/tb_unified_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ub_config.svh"

module tb_unified_buffer
    import ub_geom_pkg::*, ub_data_pkg::*;
();

    localparam logic [31:0] SEED = 32'h82588d25;
    localparam int MAX_TESTS = 16;
    localparam int FIELDS = 9;   // Values per stim line
    localparam int RAM_WORDS = 1 << `UB_RAM_ADDR_W;
    localparam int CYCLES_PER_BLOCK = 52;

    logic      clk;
    logic      reset;
    img_cfg_t  cfg;
    logic      cfg_valid;
    logic      cfg_ready;
    ram_req_t  ram_req;
    ram_word_t ram_dout = '0;
    block_t    blk;
    logic      blk_valid;
    logic      blk_ready;

    ram_word_t   mem [RAM_WORDS];
    logic [15:0] stim [MAX_TESTS * FIELDS];
    int          num_tests;
    int          cycle_limit = 0;
    int          cycles = 0;
    logic [15:0] ready_mask;
    int          stall_idx;

    unified_buffer UUT (
        .clk       (clk),
        .reset     (reset),
        .cfg       (cfg),
        .cfg_valid (cfg_valid),
        .cfg_ready (cfg_ready),
        .ram_req   (ram_req),
        .ram_dout  (ram_dout),
        .blk       (blk),
        .blk_valid (blk_valid),
        .blk_ready (blk_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Tensor RAM, one cycle read latency
    always @(posedge clk) begin
        if (ram_req.re) ram_dout <= mem[ram_req.addr];
    end

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            stop_run();
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Window origins along one axis of the padded image
    function automatic int origin_count(input int size, input int pad_a, input int pad_b);
        int padded;
        int k;
        padded = size + pad_a + pad_b;
        k = 0;
        while (k * `UB_STRIDE + `UB_WIN < padded) k++;
        return k + 1;
    endfunction

    function automatic pixel_t expect_pixel(input img_cfg_t c, input int row, input int col,
                                            input int g);
        int        w;
        int        h;
        ram_word_t word;
        pixel_t    lane;
        w = c.width;
        h = c.height;
        if (row < 0 || row >= h || col < 0 || col >= w) return '0;   // Padding
        word = mem[row * w + col];
        lane = word[`UB_LANES - 1 - g];   // Group 0 in the top lane
        return {lane[7:0], lane[15:8], lane[23:16], lane[31:24]};
    endfunction

    task automatic check_pixel(input string name, input int row, input int col,
                               input pixel_t exp, input pixel_t act);
        if (act !== exp) begin
            $display("FAILED %s pixel (%0d,%0d): expected %h actual %h",
                     name, row, col, exp, act);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act !== exp) begin
            $display("FAILED %s: expected %0d actual %0d", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_tag(input string name, input coord_t exp_row, input coord_t exp_col,
                             input group_t exp_grp, input logic exp_lg, input logic exp_lb,
                             input block_t act);
        if ({act.origin_row, act.origin_col, act.group, act.last_group, act.last_block} !==
            {exp_row, exp_col, exp_grp, exp_lg, exp_lb}) begin
            $display("FAILED %s block tag (row col group last_group last_block):", name);
            $display("FAILED %s expected %0d %0d %0d %b %b actual %0d %0d %0d %b %b", name,
                     exp_row, exp_col, exp_grp, exp_lg, exp_lb, act.origin_row,
                     act.origin_col, act.group, act.last_group, act.last_block);
            stop_run();
        end
    endtask

    task automatic load_stim();
        int total;
        for (int i = 0; i < MAX_TESTS * FIELDS; i++) stim[i] = '0;
        $readmemh("tb/ub_stim.txt", stim);
        num_tests = 0;
        total = 0;
        while (num_tests < MAX_TESTS && stim[num_tests * FIELDS] != 0) begin
            total += stim[num_tests * FIELDS + 8];
            num_tests++;
        end
        if (num_tests == 0) begin
            $display("The stimulus file holds no tests");
            stop_run();
        end
        cycle_limit = total * CYCLES_PER_BLOCK * 4 + 1000;
    endtask

    task automatic fill_ram();
        logic [31:0] state;
        state = SEED;
        for (int a = 0; a < RAM_WORDS; a++) begin
            for (int l = 0; l < `UB_LANES; l++) begin
                state = lcg_next(state);
                mem[a][l] = state;
            end
        end
    endtask

    task automatic send_cfg(input string name, input img_cfg_t c);
        @(negedge clk);
        while (!cfg_ready) @(negedge clk);
        cfg       = c;
        cfg_valid = 1'b1;
        @(negedge clk);
        cfg_valid = 1'b0;
        cfg       = '0;
        if (cfg_ready) begin
            $display("%s: cfg_ready still high after the configuration was taken", name);
            stop_run();
        end
    endtask

    // Waits for one block, stalls it by the mask, then checks and accepts it
    task automatic take_block(input string name, input img_cfg_t c, input int orow,
                              input int ocol, input int g, input logic exp_lg,
                              input logic exp_lb, output logic last);
        block_t held;
        logic   holding;
        logic   taken;
        holding = 1'b0;
        taken   = 1'b0;
        while (!taken) begin
            @(negedge clk);
            if (cfg_ready) begin
                $display("%s: cfg_ready went high while the image was in progress", name);
                stop_run();
            end
            if (!blk_valid) begin
                if (holding) begin
                    $display("%s: blk_valid dropped before the block was accepted", name);
                    stop_run();
                end
                blk_ready = 1'b0;
            end else begin
                if (holding && blk !== held) begin
                    $display("%s: block changed while it waited for blk_ready", name);
                    stop_run();
                end
                blk_ready = ready_mask[stall_idx % 16];
                stall_idx++;
                if (blk_ready) begin
                    check_tag(name, coord_t'(orow), coord_t'(ocol), group_t'(g),
                              exp_lg, exp_lb, blk);
                    for (int r = 0; r < `UB_WIN; r++) begin
                        for (int k = 0; k < `UB_WIN; k++) begin
                            check_pixel(name, r, k, expect_pixel(c, orow + r, ocol + k, g),
                                        blk.window[r][k]);
                        end
                    end
                    last  = blk.last_block;
                    taken = 1'b1;
                end else begin
                    held    = blk;
                    holding = 1'b1;
                end
            end
        end
    endtask

    task automatic run_test(input int t);
        img_cfg_t c;
        string    name;
        int       base;
        int       nr;
        int       nc;
        int       ng;
        int       n;
        int       exp_blocks;
        int       top;
        int       left;
        logic     done;
        base = t * FIELDS;
        name = $sformatf("test %0d", t + 1);
        c.width        = dim_t'(stim[base]);
        c.height       = dim_t'(stim[base + 1]);
        c.num_channels = stim[base + 2][$bits(c.num_channels)-1:0];
        c.pad_top      = pad_t'(stim[base + 3]);
        c.pad_bottom   = pad_t'(stim[base + 4]);
        c.pad_left     = pad_t'(stim[base + 5]);
        c.pad_right    = pad_t'(stim[base + 6]);
        ready_mask     = stim[base + 7];
        exp_blocks     = stim[base + 8];
        top  = c.pad_top;
        left = c.pad_left;
        nr = origin_count(c.height, c.pad_top, c.pad_bottom);
        nc = origin_count(c.width, c.pad_left, c.pad_right);
        ng = int'(c.num_channels) / `UB_LANES;
        if (int'(c.num_channels) % `UB_LANES != 0) ng++;   // Partial group still counts
        check_count({name, " walk length"}, exp_blocks, nr * nc * ng);
        send_cfg(name, c);
        stall_idx = 0;
        n = 0;
        done = 1'b0;
        // Groups innermost, then columns, then rows
        while (!done) begin
            take_block(name, c, -top + `UB_STRIDE * (n / (ng * nc)),
                       -left + `UB_STRIDE * ((n / ng) % nc), n % ng,
                       (n % ng) == ng - 1, n == nr * nc * ng - 1, done);
            n++;
        end
        @(negedge clk);
        blk_ready = 1'b0;
        if (blk_valid || !cfg_ready) begin
            $display("%s: buffer did not return to idle after the last block", name);
            stop_run();
        end
    endtask

    initial begin
        reset     = 1'b1;
        cfg       = '0;
        cfg_valid = 1'b0;
        blk_ready = 1'b0;
        load_stim();
        fill_ram();
        repeat (3) @(negedge clk);
        reset = 1'b0;
        if (!cfg_ready || blk_valid || ram_req.re) begin
            $display("Outputs are not idle after reset");
            stop_run();
        end
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/ub_stim.txt
// Columns: width height channels pad_top pad_bottom pad_left pad_right ready_mask blocks
// All values hex, one test per line, a line of zeros ends the list
0b 0b 04 0 0 0 0 ffff 0004   // 11x11, no padding, one group
09 0a 03 1 2 3 1 ffff 0009   // Uneven padding, negative origins
08 08 0d 0 0 0 0 b6db 0010   // 13 channels, four groups
07 07 05 0 0 0 0 8000 0002   // Long stalls on a single spatial block
0c 09 08 2 2 2 2 0001 0018   // Long stalls over many blocks
10 10 10 3 3 3 3 5a5a 0064   // Largest image and padding
01 01 01 3 3 3 3 ffff 0001   // One pixel, rest is padding
00 00 00 0 0 0 0 0000 0000
